// ==== hdl/box_if.sv ====
interface box_if;

	imgproc_pkg::coord_t left;
	imgproc_pkg::coord_t right;
	imgproc_pkg::coord_t top;
	imgproc_pkg::coord_t bottom;
	logic found;    // Colour seen in the last frame

	modport tracker (
		output left, right, top, bottom, found
	);

	modport user (
		input left, right, top, bottom, found
	);

endinterface

// ==== hdl/box_tracker.sv ====
module box_tracker (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                hit_i,        // Confirmed pixel of this colour
	input  logic                beat_i,
	input  logic                sop_i,
	input  imgproc_pkg::coord_t x_i,
	input  imgproc_pkg::coord_t y_i,
	input  logic                frame_end_i,
	box_if.tracker              box_o
);

	imgproc_pkg::coord_t run_left, run_right, run_top, run_bottom;
	imgproc_pkg::coord_t nxt_left, nxt_right, nxt_top, nxt_bottom;
	logic run_hit;
	logic nxt_hit;

	// Running bounds with the current beat folded in
	always_comb begin
		nxt_left   = run_left;
		nxt_right  = run_right;
		nxt_top    = run_top;
		nxt_bottom = run_bottom;
		nxt_hit    = run_hit;
		if (hit_i) begin
			if (x_i < run_left)  nxt_left  = x_i;
			if (x_i > run_right) nxt_right = x_i;
			if (y_i < run_top)   nxt_top   = y_i;
			nxt_bottom = y_i;    // Last hit is lowest so far
			nxt_hit    = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_i) begin
			if (sop_i) begin
				run_left   <= imgproc_pkg::IMAGE_W - 11'd1;  // Far corner
				run_right  <= '0;
				run_top    <= imgproc_pkg::IMAGE_H - 11'd1;
				run_bottom <= '0;
			end else begin
				run_left   <= nxt_left;
				run_right  <= nxt_right;
				run_top    <= nxt_top;
				run_bottom <= nxt_bottom;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run_hit      <= 1'b0;
			box_o.left   <= '0;
			box_o.right  <= '0;
			box_o.top    <= '0;
			box_o.bottom <= '0;
			box_o.found  <= 1'b0;
		end else begin
			if (beat_i) begin
				run_hit <= sop_i ? 1'b0 : nxt_hit;
			end
			////////////////////////////////////////
			// Latch for the overlay of the next frame
			if (frame_end_i) begin
				box_o.left   <= nxt_left;
				box_o.right  <= nxt_right;
				box_o.top    <= nxt_top;
				box_o.bottom <= nxt_bottom;
				box_o.found  <= nxt_hit;
			end
		end
	end

endmodule

// ==== hdl/colour_classifier.sv ====
module colour_classifier (
	input  logic            clk,
	input  logic            reset_n,
	pixel_stream_if.monitor pix_i,
	output logic            red_confirm_o,
	output logic            blue_confirm_o
);

	imgproc_pkg::rgb_t px;
	logic accept;
	logic red_det;
	logic blue_det;

	// Previous detects of the packet, newest in bit 0
	logic [imgproc_pkg::CONFIRM_RUN-2:0] red_hist;
	logic [imgproc_pkg::CONFIRM_RUN-2:0] blue_hist;

	assign px     = pix_i.data.rgb;
	assign accept = pix_i.valid && pix_i.ready;

	////////////////////////////////////////
	// Per-pixel rules, nine bits so sums cannot wrap
	assign red_det = ({1'b0, px.red} > {1'b0, px.green} + {1'b0, imgproc_pkg::RED_MARGIN})
		&& ({1'b0, px.red} > {1'b0, px.blue} + {1'b0, imgproc_pkg::RED_MARGIN});

	// Same as blue > green - slack, without the underflow
	assign blue_det =
		({1'b0, px.blue} + {1'b0, imgproc_pkg::BLUE_GREEN_SLACK} > {1'b0, px.green})
		&& (px.blue > px.red);

	////////////////////////////////////////
	// Run-length confirmation
	assign red_confirm_o  = red_det && (&red_hist);
	assign blue_confirm_o = blue_det && (&blue_hist);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			red_hist  <= '0;
			blue_hist <= '0;
		end else if (accept) begin
			if (pix_i.sop) begin
				// Fresh packet, no runs carried over
				red_hist  <= '0;
				blue_hist <= '0;
			end else begin
				red_hist  <= {red_hist[imgproc_pkg::CONFIRM_RUN-3:0], red_det};
				blue_hist <= {blue_hist[imgproc_pkg::CONFIRM_RUN-3:0], blue_det};
			end
		end
	end

endmodule

// ==== hdl/csr_slave.sv ====
module csr_slave (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        s_chipselect_i,
	input  logic        s_read_i,
	input  logic        s_write_i,
	input  logic [2:0]  s_address_i,
	input  logic [31:0] s_writedata_i,
	output logic [31:0] s_readdata_o,
	input  logic [7:0]  frame_count_i,
	box_if.user         red_box_i,
	box_if.user         blue_box_i,
	output logic [23:0] box_col_red_o,
	output logic [23:0] box_col_blue_o
);

	////////////////////////////////////////
	// Writable box colours
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			box_col_red_o  <= imgproc_pkg::BOX_COL_RED_DEFAULT;
			box_col_blue_o <= imgproc_pkg::BOX_COL_BLUE_DEFAULT;
		end else if (s_chipselect_i && s_write_i) begin
			if (s_address_i == imgproc_pkg::ADDR_COL_RED)
				box_col_red_o <= s_writedata_i[23:0];
			if (s_address_i == imgproc_pkg::ADDR_COL_BLUE)
				box_col_blue_o <= s_writedata_i[23:0];
		end
	end

	// Read data lands one cycle after the strobe
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata_o <= '0;
		end else if (s_chipselect_i && s_read_i) begin
			case (s_address_i)
				imgproc_pkg::ADDR_STATUS:
					s_readdata_o <= {16'h0, frame_count_i, 6'h0,
						blue_box_i.found, red_box_i.found};
				imgproc_pkg::ADDR_RED_LR:
					s_readdata_o <= {5'h0, red_box_i.left, 5'h0, red_box_i.right};
				imgproc_pkg::ADDR_RED_TB:
					s_readdata_o <= {5'h0, red_box_i.top, 5'h0, red_box_i.bottom};
				imgproc_pkg::ADDR_BLUE_LR:
					s_readdata_o <= {5'h0, blue_box_i.left, 5'h0, blue_box_i.right};
				imgproc_pkg::ADDR_BLUE_TB:
					s_readdata_o <= {5'h0, blue_box_i.top, 5'h0, blue_box_i.bottom};
				imgproc_pkg::ADDR_ID:
					s_readdata_o <= imgproc_pkg::IMGPROC_ID;
				imgproc_pkg::ADDR_COL_RED:
					s_readdata_o <= {8'h0, box_col_red_o};
				default:
					s_readdata_o <= {8'h0, box_col_blue_o};  // ADDR_COL_BLUE
			endcase
		end
	end

endmodule

// ==== hdl/eee_imgproc.sv ====
module eee_imgproc (
	input  logic        clk,
	input  logic        reset_n,
	// Pixel stream in
	input  logic [23:0] sink_data_i,
	input  logic        sink_valid_i,
	input  logic        sink_sop_i,
	input  logic        sink_eop_i,
	output logic        sink_ready_o,
	// Pixel stream out
	output logic [23:0] source_data_o,
	output logic        source_valid_o,
	output logic        source_sop_o,
	output logic        source_eop_o,
	input  logic        source_ready_i,
	input  logic        mode_i,           // High enables the overlay
	// Register slave
	input  logic        s_chipselect_i,
	input  logic        s_read_i,
	input  logic        s_write_i,
	input  logic [2:0]  s_address_i,
	input  logic [31:0] s_writedata_i,
	output logic [31:0] s_readdata_o
);

	pixel_stream_if ext_in ();
	pixel_stream_if pix_in ();
	pixel_stream_if pix_out ();
	pixel_stream_if ext_out ();
	box_if red_box ();
	box_if blue_box ();

	imgproc_pkg::coord_t x, y;
	imgproc_pkg::pixel_word_u mix_data;
	logic video, frame_end, beat;
	logic red_confirm, blue_confirm;
	logic [7:0] frame_count;
	logic [23:0] box_col_red, box_col_blue;

	////////////////////////////////////////
	// Stream edges and the path between the registers
	assign ext_in.data    = sink_data_i;
	assign ext_in.valid   = sink_valid_i;
	assign ext_in.sop     = sink_sop_i;
	assign ext_in.eop     = sink_eop_i;
	assign sink_ready_o   = ext_in.ready;
	assign source_data_o  = ext_out.data;
	assign source_valid_o = ext_out.valid;
	assign source_sop_o   = ext_out.sop;
	assign source_eop_o   = ext_out.eop;
	assign ext_out.ready  = source_ready_i;

	assign pix_out.data  = mix_data;
	assign pix_out.valid = pix_in.valid;
	assign pix_out.sop   = pix_in.sop;
	assign pix_out.eop   = pix_in.eop;
	assign pix_in.ready  = pix_out.ready;
	assign beat          = pix_in.valid && pix_in.ready;  // Beat moving between registers

	stream_reg u_in_reg (.clk(clk), .reset_n(reset_n), .up_i(ext_in), .dn_o(pix_in));
	stream_reg u_out_reg (.clk(clk), .reset_n(reset_n), .up_i(pix_out), .dn_o(ext_out));

	frame_position u_frame_position (
		.clk(clk), .reset_n(reset_n), .pix_i(pix_in), .x_o(x), .y_o(y),
		.video_o(video), .frame_end_o(frame_end), .frame_count_o(frame_count)
	);

	colour_classifier u_colour_classifier (
		.clk(clk), .reset_n(reset_n), .pix_i(pix_in),
		.red_confirm_o(red_confirm), .blue_confirm_o(blue_confirm)
	);

	box_tracker u_red_box (
		.clk(clk), .reset_n(reset_n), .hit_i(red_confirm), .beat_i(beat),
		.sop_i(pix_in.sop), .x_i(x), .y_i(y), .frame_end_i(frame_end), .box_o(red_box)
	);

	box_tracker u_blue_box (
		.clk(clk), .reset_n(reset_n), .hit_i(blue_confirm), .beat_i(beat),
		.sop_i(pix_in.sop), .x_i(x), .y_i(y), .frame_end_i(frame_end), .box_o(blue_box)
	);

	overlay_mixer u_overlay_mixer (
		.pix_i(pix_in), .mode_i(mode_i), .video_i(video), .x_i(x), .y_i(y),
		.red_confirm_i(red_confirm), .blue_confirm_i(blue_confirm),
		.red_box_i(red_box), .blue_box_i(blue_box),
		.box_col_red_i(box_col_red), .box_col_blue_i(box_col_blue), .data_o(mix_data)
	);

	csr_slave u_csr_slave (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect_i(s_chipselect_i), .s_read_i(s_read_i), .s_write_i(s_write_i),
		.s_address_i(s_address_i), .s_writedata_i(s_writedata_i),
		.s_readdata_o(s_readdata_o), .frame_count_i(frame_count),
		.red_box_i(red_box), .blue_box_i(blue_box),
		.box_col_red_o(box_col_red), .box_col_blue_o(box_col_blue)
	);

endmodule

// ==== hdl/frame_position.sv ====
module frame_position (
	input  logic                 clk,
	input  logic                 reset_n,
	pixel_stream_if.monitor      pix_i,
	output imgproc_pkg::coord_t  x_o,
	output imgproc_pkg::coord_t  y_o,
	output logic                 video_o,
	output logic                 frame_end_o,
	output logic [7:0]           frame_count_o
);

	logic accept;

	assign accept = pix_i.valid && pix_i.ready;

	// Last beat of a video packet closes the frame
	assign frame_end_o = accept && pix_i.eop && !pix_i.sop && video_o;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x_o     <= '0;
			y_o     <= '0;
			video_o <= 1'b0;
		end else if (accept) begin
			if (pix_i.sop) begin
				x_o     <= '0;
				y_o     <= '0;
				video_o <= (pix_i.data.desc.packet_type == imgproc_pkg::VIDEO_PACKET_TYPE);
			end else if (x_o == imgproc_pkg::IMAGE_W - 11'd1) begin
				x_o <= '0;              // Wrap to next line
				y_o <= y_o + 11'd1;
			end else begin
				x_o <= x_o + 11'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_count_o <= '0;
		end else if (frame_end_o) begin
			frame_count_o <= frame_count_o + 8'd1;  // Wraps at 256
		end
	end

endmodule

// ==== hdl/imgproc_pkg.sv ====
package imgproc_pkg;

	////////////////////////////////////////
	// Frame geometry
	typedef logic [10:0] coord_t;

	localparam coord_t IMAGE_W = 11'd640;
	localparam coord_t IMAGE_H = 11'd480;

	////////////////////////////////////////
	// Detection thresholds
	localparam logic [7:0] RED_MARGIN       = 8'd30;  // Red over green and blue
	localparam logic [7:0] BLUE_GREEN_SLACK = 8'd20;  // Blue may trail green by this
	localparam logic [7:0] CONFIRM_RUN      = 8'd6;   // Current beat plus five before

	// Highlight and box colours
	localparam logic [23:0] COL_RED             = 24'hff0000;
	localparam logic [23:0] COL_BLUE            = 24'h0000ff;
	localparam logic [23:0] BOX_COL_RED_DEFAULT  = 24'hff0000;
	localparam logic [23:0] BOX_COL_BLUE_DEFAULT = 24'h0000ff;

	////////////////////////////////////////
	// Packets and registers
	localparam logic [3:0]  VIDEO_PACKET_TYPE = 4'h0;
	localparam logic [31:0] IMGPROC_ID        = 32'h1234EEE2;

	localparam logic [2:0] ADDR_STATUS   = 3'd0;
	localparam logic [2:0] ADDR_RED_LR   = 3'd1;
	localparam logic [2:0] ADDR_RED_TB   = 3'd2;
	localparam logic [2:0] ADDR_BLUE_LR  = 3'd3;
	localparam logic [2:0] ADDR_BLUE_TB  = 3'd4;
	localparam logic [2:0] ADDR_ID       = 3'd5;
	localparam logic [2:0] ADDR_COL_RED  = 3'd6;
	localparam logic [2:0] ADDR_COL_BLUE = 3'd7;

	// Pixel word, red in the top byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Start-of-packet word, type nibble at the bottom
	typedef struct packed {
		logic [19:0] reserved;
		logic [3:0]  packet_type;
	} descriptor_t;

	typedef union packed {
		rgb_t        rgb;
		descriptor_t desc;
	} pixel_word_u;

endpackage

// ==== hdl/overlay_mixer.sv ====
module overlay_mixer (
	pixel_stream_if.monitor          pix_i,
	input  logic                     mode_i,
	input  logic                     video_i,
	input  imgproc_pkg::coord_t      x_i,
	input  imgproc_pkg::coord_t      y_i,
	input  logic                     red_confirm_i,
	input  logic                     blue_confirm_i,
	box_if.user                      red_box_i,
	box_if.user                      blue_box_i,
	input  logic [23:0]              box_col_red_i,
	input  logic [23:0]              box_col_blue_i,
	output imgproc_pkg::pixel_word_u data_o
);

	imgproc_pkg::rgb_t px;
	logic [7:0] grey;
	logic red_edge;
	logic blue_edge;

	assign px   = pix_i.data.rgb;
	assign grey = px.green[7:1] + px.red[7:2] + px.blue[7:2];  // g/2 + r/4 + b/4

	// On any side of a box found last frame
	assign red_edge = red_box_i.found
		&& ((x_i == red_box_i.left) || (x_i == red_box_i.right)
		|| (y_i == red_box_i.top) || (y_i == red_box_i.bottom));
	assign blue_edge = blue_box_i.found
		&& ((x_i == blue_box_i.left) || (x_i == blue_box_i.right)
		|| (y_i == blue_box_i.top) || (y_i == blue_box_i.bottom));

	always_comb begin
		data_o = pix_i.data;  // Descriptor and non-video data untouched
		if (mode_i && video_i && !pix_i.sop) begin
			if (red_edge)            data_o.rgb = box_col_red_i;
			else if (blue_edge)      data_o.rgb = box_col_blue_i;
			else if (red_confirm_i)  data_o.rgb = imgproc_pkg::COL_RED;
			else if (blue_confirm_i) data_o.rgb = imgproc_pkg::COL_BLUE;
			else                     data_o.rgb = {grey, grey, grey};
		end
	end

endmodule

// ==== hdl/pixel_stream_if.sv ====
interface pixel_stream_if;

	imgproc_pkg::pixel_word_u data;
	logic valid;
	logic sop;    // Start of packet
	logic eop;    // End of packet
	logic ready;

	modport source (
		output data, valid, sop, eop,
		input  ready
	);

	modport sink (
		input  data, valid, sop, eop,
		output ready
	);

	// Watches the link without driving anything
	modport monitor (
		input data, valid, sop, eop, ready
	);

endinterface

// ==== hdl/stream_reg.sv ====
module stream_reg (
	input  logic           clk,
	input  logic           reset_n,
	pixel_stream_if.sink   up_i,
	pixel_stream_if.source dn_o
);

	logic load;

	// Slot is free when empty or being drained this cycle
	assign load       = dn_o.ready || !dn_o.valid;
	assign up_i.ready = load;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			dn_o.valid <= 1'b0;
		end else if (load) begin
			dn_o.valid <= up_i.valid;
		end
	end

	// Payload only moves with a real beat
	always_ff @(posedge clk) begin
		if (load && up_i.valid) begin
			dn_o.data <= up_i.data;
			dn_o.sop  <= up_i.sop;
			dn_o.eop  <= up_i.eop;
		end
	end

endmodule

// ==== list.f ====
hdl/imgproc_pkg.sv
hdl/pixel_stream_if.sv
hdl/box_if.sv
hdl/stream_reg.sv
hdl/frame_position.sv
hdl/colour_classifier.sv
hdl/box_tracker.sv
hdl/overlay_mixer.sv
hdl/csr_slave.sv
hdl/eee_imgproc.sv
test/tb_imgproc.sv

// ==== test/tb_imgproc.sv ====
module tb_imgproc;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD  = 40;
	localparam int LINE_W      = imgproc_pkg::IMAGE_W;
	localparam int FRAME_BEATS = 3 * LINE_W + 1;         // Patch frames hold three lines
	localparam int TOTAL_BEATS = 4 * FRAME_BEATS + 700;  // Every test together
	localparam int TIMEOUT_NS  = (TOTAL_BEATS * 4 + 400) * CLK_PERIOD;

	localparam int RED_MARGIN  = imgproc_pkg::RED_MARGIN;
	localparam int BLUE_SLACK  = imgproc_pkg::BLUE_GREEN_SLACK;
	localparam int RUN_BEFORE  = imgproc_pkg::CONFIRM_RUN - 1;

	localparam logic [23:0] NEUTRAL_PIX = 24'h404040;  // Grey of itself and neither colour
	localparam logic [23:0] RED_PIX     = 24'hc82020;
	localparam logic [23:0] BLUE_PIX    = 24'h2030c8;

	logic        clk = 1'b0;
	logic        reset_n;
	logic [23:0] sink_data;
	logic        sink_valid, sink_sop, sink_eop, sink_ready;
	logic [23:0] source_data;
	logic        source_valid, source_sop, source_eop, source_ready;
	logic        mode;
	logic        s_chipselect, s_read, s_write;
	logic [2:0]  s_address;
	logic [31:0] s_writedata, s_readdata;

	logic        random_ready;
	int          errors = 0;
	logic [31:0] lfsr_state = 32'h6292_996a;

	logic [25:0] stim_q[$];  // {sop, eop, data}
	logic [25:0] exp_q[$];
	logic [25:0] out_q[$];
	logic [23:0] pix_q[$];

	// Reference state with index 0 red and 1 blue
	int          m_x, m_y;
	logic        m_video;
	logic [7:0]  m_frames;
	int          m_run[2];
	int          run_l[2], run_r[2], run_t[2], run_b[2];
	logic        run_hit[2];
	int          box_l[2], box_r[2], box_t[2], box_b[2];
	logic        box_found[2];
	logic [23:0] box_col[2];

	eee_imgproc u_dut (
		.clk(clk), .reset_n(reset_n),
		.sink_data_i(sink_data), .sink_valid_i(sink_valid), .sink_sop_i(sink_sop),
		.sink_eop_i(sink_eop), .sink_ready_o(sink_ready),
		.source_data_o(source_data), .source_valid_o(source_valid),
		.source_sop_o(source_sop), .source_eop_o(source_eop), .source_ready_i(source_ready),
		.mode_i(mode),
		.s_chipselect_i(s_chipselect), .s_read_i(s_read), .s_write_i(s_write),
		.s_address_i(s_address), .s_writedata_i(s_writedata), .s_readdata_o(s_readdata)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	// Output back-pressure is random only while enabled
	initial begin
		forever begin
			@(negedge clk);
			source_ready = random_ready ? lfsr_bit() : 1'b1;
		end
	end

	// Records every beat that leaves on the source side
	initial begin
		forever begin
			@(negedge clk);
			#1;
			if (reset_n && source_valid && source_ready)
				out_q.push_back({source_sop, source_eop, source_data});
		end
	end

	////////////////////////////////////////
	// Random numbers

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic int beat_index(input int x, input int y);
		return 1 + y * LINE_W + x;  // Descriptor word comes first
	endfunction

	////////////////////////////////////////
	// Checks and register access

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic csr_read(input logic [2:0] addr, output logic [31:0] data);
		@(negedge clk);
		s_chipselect = 1'b1;
		s_read       = 1'b1;
		s_address    = addr;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		data         = s_readdata;  // Registered one cycle after the strobe
	endtask

	task automatic csr_write(input logic [2:0] addr, input logic [31:0] data);
		@(negedge clk);
		s_chipselect = 1'b1;
		s_write      = 1'b1;
		s_address    = addr;
		s_writedata  = data;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_write      = 1'b0;
	endtask

	task automatic check_reg(input string name, input logic [2:0] addr,
		input logic [31:0] expected);
		logic [31:0] data;
		csr_read(addr, data);
		check_value(name, expected, data);
	endtask

	////////////////////////////////////////
	// Expected stream

	task automatic model_beat(input logic [25:0] beat);
		int r, g, b;
		logic [7:0] grey;
		logic [23:0] o;
		logic det[2];
		logic conf[2];
		logic on_edge[2];
		r = beat[23:16];
		g = beat[15:8];
		b = beat[7:0];
		o = beat[23:0];
		if (beat[25]) begin
			m_video = (beat[3:0] == imgproc_pkg::VIDEO_PACKET_TYPE);
			m_x = 0;
			m_y = 0;
			for (int c = 0; c < 2; c++) begin
				m_run[c]   = 0;
				run_l[c]   = LINE_W - 1;
				run_r[c]   = 0;
				run_t[c]   = imgproc_pkg::IMAGE_H - 1;
				run_b[c]   = 0;
				run_hit[c] = 1'b0;
			end
		end else begin
			det[0] = (r > g + RED_MARGIN) && (r > b + RED_MARGIN);
			det[1] = (b + BLUE_SLACK > g) && (b > r);
			for (int c = 0; c < 2; c++) begin
				conf[c]    = det[c] && (m_run[c] >= RUN_BEFORE);
				m_run[c]   = det[c] ? m_run[c] + 1 : 0;
				on_edge[c] = box_found[c] && (m_x == box_l[c] || m_x == box_r[c]
					|| m_y == box_t[c] || m_y == box_b[c]);
			end
			grey = 8'(g / 2 + r / 4 + b / 4);
			if (mode && m_video) begin
				if (on_edge[0])   o = box_col[0];
				else if (on_edge[1]) o = box_col[1];
				else if (conf[0]) o = 24'hff0000;
				else if (conf[1]) o = 24'h0000ff;
				else              o = {grey, grey, grey};
			end
			for (int c = 0; c < 2; c++) begin
				if (conf[c]) begin
					run_l[c]   = (m_x < run_l[c]) ? m_x : run_l[c];
					run_r[c]   = (m_x > run_r[c]) ? m_x : run_r[c];
					run_t[c]   = (m_y < run_t[c]) ? m_y : run_t[c];
					run_b[c]   = m_y;
					run_hit[c] = 1'b1;
				end
			end
			if (beat[24] && m_video) begin
				// Boxes of this frame apply from the next packet
				for (int c = 0; c < 2; c++) begin
					box_l[c]     = run_l[c];
					box_r[c]     = run_r[c];
					box_t[c]     = run_t[c];
					box_b[c]     = run_b[c];
					box_found[c] = run_hit[c];
				end
				m_frames++;
			end
			if (m_x == LINE_W - 1) begin
				m_x = 0;
				m_y++;
			end else begin
				m_x++;
			end
		end
		exp_q.push_back({beat[25:24], o});
	endtask

	task automatic add_packet(input logic [3:0] ptype);
		logic [31:0] r;
		logic [25:0] beat;
		r    = rand_bits(20);
		beat = {2'b10, r[19:0], ptype};
		stim_q.push_back(beat);
		model_beat(beat);
		foreach (pix_q[i]) begin
			beat = {1'b0, i == pix_q.size() - 1, pix_q[i]};
			stim_q.push_back(beat);
			model_beat(beat);
		end
		pix_q.delete();
	endtask

	task automatic add_pixels(input logic [23:0] colour, input int n);
		repeat (n) pix_q.push_back(colour);
	endtask

	task automatic add_random_pixels(input int n);
		repeat (n) pix_q.push_back(rand_bits(24));
	endtask

	// Three lines with a ten-pixel patch on lines 1 and 2
	task automatic add_patch_frame(input logic [23:0] colour, input int x0);
		for (int y = 0; y < 3; y++)
			for (int x = 0; x < LINE_W; x++)
				pix_q.push_back((y > 0 && x >= x0 && x < x0 + 10) ? colour : NEUTRAL_PIX);
		add_packet(imgproc_pkg::VIDEO_PACKET_TYPE);
	endtask

	task automatic clear_queues();
		stim_q.delete();
		exp_q.delete();
		out_q.delete();
	endtask

	task automatic run_stream(input string name);
		logic accepted;
		int cycles;
		int limit;
		limit = 4 * exp_q.size() + 100;
		@(negedge clk);
		foreach (stim_q[i]) begin
			sink_sop   = stim_q[i][25];
			sink_eop   = stim_q[i][24];
			sink_data  = stim_q[i][23:0];
			sink_valid = 1'b1;
			do begin
				#1;
				accepted = sink_ready;
				@(negedge clk);
			end while (!accepted);
		end
		sink_valid = 1'b0;
		cycles = 0;
		while (out_q.size() < exp_q.size() && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		repeat (4) @(negedge clk);  // Room for a stray extra beat
		assert (cycles < limit) else begin
			errors++;
			$display("%s: output stalled, only %0d of %0d beats came out",
				name, out_q.size(), exp_q.size());
		end
		assert (out_q.size() == exp_q.size()) else begin
			errors++;
			$display("[FAIL] %s beat count expected %0d actual %0d",
				name, exp_q.size(), out_q.size());
		end
		foreach (exp_q[i])
			if (i < out_q.size())
				check_value($sformatf("%s beat %0d", name, i), {6'h0, exp_q[i]},
					{6'h0, out_q[i]});
	endtask

	////////////////////////////////////////
	// Tests

	task automatic test_reset_passthrough();
		check_value("reset_passthrough source_valid", 32'd0, {31'd0, source_valid});
		check_reg("reset_passthrough ID", imgproc_pkg::ADDR_ID, 32'h1234eee2);
		check_reg("reset_passthrough COL_RED", imgproc_pkg::ADDR_COL_RED, 32'h00ff0000);
		check_reg("reset_passthrough COL_BLUE", imgproc_pkg::ADDR_COL_BLUE, 32'h000000ff);
		check_reg("reset_passthrough STATUS", imgproc_pkg::ADDR_STATUS, 32'h0);
		mode = 1'b0;
		clear_queues();
		add_random_pixels(48);
		add_packet(4'h0);
		add_random_pixels(20);
		add_packet(4'hf);  // Not video
		run_stream("reset_passthrough");
	endtask

	task automatic test_grey_mode();
		mode = 1'b1;
		clear_queues();
		add_random_pixels(64);
		add_packet(4'h0);
		add_pixels(NEUTRAL_PIX, 40);  // Leaves no box behind
		add_packet(4'h0);
		add_random_pixels(24);
		add_packet(4'h3);
		run_stream("grey_mode");
		check_reg("grey_mode STATUS", imgproc_pkg::ADDR_STATUS, {16'h0, m_frames, 8'h00});
	endtask

	task automatic test_confirm_runs();
		mode = 1'b1;
		clear_queues();
		add_pixels(NEUTRAL_PIX, 2);
		add_pixels(RED_PIX, 8);     // x 2 to 9
		add_pixels(NEUTRAL_PIX, 2);
		add_pixels(BLUE_PIX, 8);    // x 12 to 19
		add_pixels(NEUTRAL_PIX, 2);
		add_pixels(RED_PIX, 5);     // x 22 to 26 is too short
		add_pixels(NEUTRAL_PIX, 3);
		add_packet(4'h0);
		run_stream("confirm_runs");
		check_value("confirm_runs red 5th", 32'h4a4a4a, out_q[beat_index(6, 0)][23:0]);
		check_value("confirm_runs red 6th", 32'hff0000, out_q[beat_index(7, 0)][23:0]);
		check_value("confirm_runs red 8th", 32'hff0000, out_q[beat_index(9, 0)][23:0]);
		check_value("confirm_runs blue 5th", 32'h525252, out_q[beat_index(16, 0)][23:0]);
		check_value("confirm_runs blue 6th", 32'h0000ff, out_q[beat_index(17, 0)][23:0]);
		check_value("confirm_runs short run", 32'h4a4a4a, out_q[beat_index(26, 0)][23:0]);
	endtask

	task automatic test_red_box();
		logic [7:0] frames_before;
		mode = 1'b1;
		frames_before = m_frames;
		clear_queues();
		add_patch_frame(RED_PIX, 100);  // Confirmed from x 105
		run_stream("red_box patch");
		check_reg("red_box RED_LR", imgproc_pkg::ADDR_RED_LR, {5'h0, 11'd105, 5'h0, 11'd109});
		check_reg("red_box RED_TB", imgproc_pkg::ADDR_RED_TB, {5'h0, 11'd1, 5'h0, 11'd2});
		check_reg("red_box STATUS", imgproc_pkg::ADDR_STATUS,
			{16'h0, frames_before + 8'd1, 8'h01});
		clear_queues();
		add_patch_frame(NEUTRAL_PIX, 0);
		run_stream("red_box overlay");
		check_value("red_box left edge", 32'hff0000, out_q[beat_index(105, 0)][23:0]);
		check_value("red_box bottom edge", 32'hff0000, out_q[beat_index(300, 2)][23:0]);
		check_value("red_box outside", 32'h404040, out_q[beat_index(300, 0)][23:0]);
	endtask

	task automatic test_box_colour();
		mode = 1'b1;
		csr_write(imgproc_pkg::ADDR_COL_BLUE, 32'hab123456);
		box_col[1] = 24'h123456;
		check_reg("box_colour COL_BLUE", imgproc_pkg::ADDR_COL_BLUE, 32'h00123456);
		check_reg("box_colour COL_RED", imgproc_pkg::ADDR_COL_RED, 32'h00ff0000);
		clear_queues();
		add_patch_frame(BLUE_PIX, 200);
		run_stream("box_colour patch");
		check_reg("box_colour BLUE_LR", imgproc_pkg::ADDR_BLUE_LR, {5'h0, 11'd205, 5'h0, 11'd209});
		check_reg("box_colour BLUE_TB", imgproc_pkg::ADDR_BLUE_TB, {5'h0, 11'd1, 5'h0, 11'd2});
		clear_queues();
		add_patch_frame(NEUTRAL_PIX, 0);
		run_stream("box_colour overlay");
		check_value("box_colour left edge", 32'h123456, out_q[beat_index(205, 0)][23:0]);
		check_value("box_colour top edge", 32'h123456, out_q[beat_index(400, 1)][23:0]);
		check_value("box_colour outside", 32'h404040, out_q[beat_index(400, 0)][23:0]);
	endtask

	task automatic test_backpressure();
		mode = 1'b1;
		clear_queues();
		add_random_pixels(120);
		add_pixels(RED_PIX, 8);
		add_random_pixels(80);
		add_packet(4'h0);
		add_random_pixels(30);
		add_packet(4'h5);
		random_ready = 1'b1;
		run_stream("backpressure");
		random_ready = 1'b0;
	endtask

	initial begin
		reset_n      = 1'b0;
		sink_data    = '0;
		sink_valid   = 1'b0;
		sink_sop     = 1'b0;
		sink_eop     = 1'b0;
		source_ready = 1'b1;
		random_ready = 1'b0;
		mode         = 1'b0;
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		s_write      = 1'b0;
		s_address    = '0;
		s_writedata  = '0;
		m_frames     = '0;
		box_found    = '{1'b0, 1'b0};
		box_col      = '{imgproc_pkg::BOX_COL_RED_DEFAULT, imgproc_pkg::BOX_COL_BLUE_DEFAULT};
		repeat (16) @(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);

		test_reset_passthrough();
		test_grey_mode();
		test_confirm_runs();
		test_red_box();
		test_box_colour();
		test_backpressure();

		$display("Tests done with %0d errors", errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
